//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_z80_datapath
FILELIST = list.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

//--- hw/z80_acc_flag_unit.sv
`timescale 1ns/1ns

module z80_acc_flag_unit (
  input  logic                  clk,
  input  logic                  arst_n,
  input  z80_dp_pkg::micro_op_t op,
  input  z80_dp_pkg::byte_t     alu_result,
  input  z80_dp_pkg::byte_t     alu_flags,
  output z80_dp_pkg::byte_t     a_value,
  output z80_dp_pkg::byte_t     f_value
);

  import z80_dp_pkg::*;

  byte_t a_q;
  byte_t f_q;
  byte_t a_sh_q;
  byte_t f_sh_q;

  // new flag byte before it is written
  byte_t f_base;
  byte_t f_next;
  logic  ovr_any;
  logic  f_wr;

  // a set or clear wins over the incoming bit, keep lets it through
  function automatic logic apply_ovr(flag_ovr_e ovr, logic cur);
    logic res;
    unique case (ovr)
      ovr_set:   res = 1'b1;
      ovr_clear: res = 1'b0;
      default:   res = cur;
    endcase
    return res;
  endfunction

  // ------------------------------------------------------------
  // flag merge
  // ------------------------------------------------------------

  assign ovr_any = (op.ovr.s != ovr_keep) || (op.ovr.z != ovr_keep) ||
                   (op.ovr.h != ovr_keep) || (op.ovr.pv != ovr_keep) ||
                   (op.ovr.n != ovr_keep) || (op.ovr.c != ovr_keep);
  assign f_wr    = op.ld_f || ovr_any;

  always_comb begin
    // start from the ALU flags on ld_f, else from what F holds now
    f_base = op.ld_f ? alu_flags : f_q;
    f_next = f_base;
    f_next[flag_s_bit]  = apply_ovr(op.ovr.s, f_base[flag_s_bit]);
    f_next[flag_z_bit]  = apply_ovr(op.ovr.z, f_base[flag_z_bit]);
    f_next[flag_h_bit]  = apply_ovr(op.ovr.h, f_base[flag_h_bit]);
    f_next[flag_pv_bit] = apply_ovr(op.ovr.pv, f_base[flag_pv_bit]);
    f_next[flag_n_bit]  = apply_ovr(op.ovr.n, f_base[flag_n_bit]);
    f_next[flag_c_bit]  = apply_ovr(op.ovr.c, f_base[flag_c_bit]);
  end

  // ------------------------------------------------------------
  // A, F and the shadow pair
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q    <= '0;
      f_q    <= '0;
      a_sh_q <= '0;
      f_sh_q <= '0;
    end else if (op.ex_af) begin
      // the exchange owns both registers for this cycle
      a_q    <= a_sh_q;
      a_sh_q <= a_q;
      f_q    <= f_sh_q;
      f_sh_q <= f_q;
    end else begin
      // an ALU op may load A and F in the same cycle
      if (op.ld_a) begin
        a_q <= alu_result;
      end
      if (f_wr) begin
        f_q <= f_next;
      end
    end
  end

  assign a_value = a_q;
  assign f_value = f_q;

endmodule

//--- hw/z80_alu8.sv
`timescale 1ns/1ns

module z80_alu8 (
  input  z80_dp_pkg::byte_t   a,
  input  z80_dp_pkg::byte_t   b,
  input  z80_dp_pkg::byte_t   f_in,
  input  z80_dp_pkg::alu_op_e op,
  output z80_dp_pkg::byte_t   result,
  output z80_dp_pkg::byte_t   f_out
);

  import z80_dp_pkg::*;

  // the add runs as two nibble adders so the half carry is a real wire
  logic       lo_carry;
  logic       hi_carry;
  logic [3:0] lo_sum;
  logic [3:0] hi_sum;

  // a is always the accumulator and b is always the internal bus
  always_comb begin
    result   = b;
    f_out    = f_in;
    lo_carry = 1'b0;
    hi_carry = 1'b0;
    lo_sum   = '0;
    hi_sum   = '0;

    unique case (op)
      alu_inc: begin
        // increment leaves every flag alone
        result = a + byte_t'(1);
      end

      alu_dec: begin
        result = a - byte_t'(1);
        // PV tells the control side that the count has not run out yet
        f_out[flag_pv_bit] = (result != '0);
      end

      alu_add: begin
        // low nibble first, its carry out is the half carry
        {lo_carry, lo_sum} = {1'b0, a[3:0]} + {1'b0, b[3:0]};
        {hi_carry, hi_sum} = {1'b0, a[7:4]} + {1'b0, b[7:4]} + {4'd0, lo_carry};
        result = {hi_sum, lo_sum};
        f_out[flag_h_bit] = lo_carry;
        f_out[flag_c_bit] = hi_carry;
        f_out[flag_s_bit] = result[data_w-1];
        f_out[flag_z_bit] = (result == '0);
      end

      alu_sub: begin
        // the bus is the minuend, A is what gets taken away
        result = b - a;
        // a borrow out of bit 3 happens exactly when the low nibble of b is smaller
        f_out[flag_h_bit] = (b[3:0] < a[3:0]);
        f_out[flag_c_bit] = (b < a);
        f_out[flag_s_bit] = result[data_w-1];
        f_out[flag_z_bit] = (result == '0);
      end

      default: begin
        // pass-through and the unused codes just hand the bus to A
        result = b;
      end
    endcase
  end

endmodule

//--- hw/z80_bus_select.sv
`timescale 1ns/1ns

module z80_bus_select (
  input  z80_dp_pkg::bus_src_e src,
  input  z80_dp_pkg::byte_t    data_in,
  input  z80_dp_pkg::byte_t    reg_value,
  input  z80_dp_pkg::byte_t    a_value,
  input  z80_dp_pkg::byte_t    f_value,
  output z80_dp_pkg::byte_t    bus_value,
  output logic                 data_oe
);

  import z80_dp_pkg::*;

  // ------------------------------------------------------------
  // one driver on the internal bus
  // ------------------------------------------------------------

  // the src code names exactly one source, so no two drivers can meet
  always_comb begin
    unique case (src)
      src_reg: bus_value = reg_value;
      src_a:   bus_value = a_value;
      src_f:   bus_value = f_value;
      default: bus_value = data_in;
    endcase
  end

  // when an internal block owns the bus it is also shown outside
  // and the pins read external data in every other cycle
  assign data_oe = (src != src_ext);

endmodule

//--- hw/z80_datapath.sv
`timescale 1ns/1ns

module z80_datapath (
  input  logic                  clk,
  input  logic                  arst_n,
  input  z80_dp_pkg::micro_op_t op,
  input  z80_dp_pkg::byte_t     data_in,
  output z80_dp_pkg::byte_t     data_out,
  output logic                  data_oe,
  output z80_dp_pkg::byte_t     flags
);

  import z80_dp_pkg::*;

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------

  byte_t reg_value;
  byte_t a_value;
  byte_t f_value;
  byte_t bus_value;
  byte_t alu_result;
  byte_t alu_flags;

  z80_register_file u_register_file (
    .clk        (clk),
    .arst_n     (arst_n),
    .op         (op),
    .load_value (bus_value),
    .reg_value  (reg_value)
  );

  z80_acc_flag_unit u_acc_flag_unit (
    .clk        (clk),
    .arst_n     (arst_n),
    .op         (op),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .a_value    (a_value),
    .f_value    (f_value)
  );

  // the ALU sees A on one side and the bus on the other
  z80_alu8 u_alu8 (
    .a      (a_value),
    .b      (bus_value),
    .f_in   (f_value),
    .op     (op.alu_op),
    .result (alu_result),
    .f_out  (alu_flags)
  );

  z80_bus_select u_bus_select (
    .src       (op.src),
    .data_in   (data_in),
    .reg_value (reg_value),
    .a_value   (a_value),
    .f_value   (f_value),
    .bus_value (bus_value),
    .data_oe   (data_oe)
  );

  // data_out carries the bus in every cycle, data_oe says when it is valid
  assign data_out = bus_value;
  assign flags    = f_value;

endmodule

//--- hw/z80_dp_pkg.sv
package z80_dp_pkg;

  // ------------------------------------------------------------
  // widths and flag positions
  // ------------------------------------------------------------

  // every register and the internal bus are one byte wide
  localparam int data_w = 8;

  // number of general registers B, C, D, E, H, L
  localparam int num_regs = 6;

  typedef logic [data_w-1:0] byte_t;

  // bit positions inside F, bits 5 and 3 are unused
  localparam int flag_s_bit  = 7;
  localparam int flag_z_bit  = 6;
  localparam int flag_h_bit  = 4;
  localparam int flag_pv_bit = 2;
  localparam int flag_n_bit  = 1;
  localparam int flag_c_bit  = 0;

  // ------------------------------------------------------------
  // control encodings
  // ------------------------------------------------------------

  // general register names, codes 6 and 7 name no register
  typedef enum logic [2:0] {
    reg_b = 3'd0,
    reg_c = 3'd1,
    reg_d = 3'd2,
    reg_e = 3'd3,
    reg_h = 3'd4,
    reg_l = 3'd5
  } reg_id_e;

  // who drives the internal data bus this cycle
  typedef enum logic [1:0] {
    src_ext = 2'd0,
    src_reg = 2'd1,
    src_a   = 2'd2,
    src_f   = 2'd3
  } bus_src_e;

  typedef enum logic [2:0] {
    alu_pass = 3'd0,
    alu_inc  = 3'd1,
    alu_dec  = 3'd2,
    alu_add  = 3'd3,
    alu_sub  = 3'd4
  } alu_op_e;

  // per-flag force applied after the ALU flags
  typedef enum logic [1:0] {
    ovr_keep  = 2'd0,
    ovr_clear = 2'd1,
    ovr_set   = 2'd2
  } flag_ovr_e;

  typedef struct packed {
    flag_ovr_e s;
    flag_ovr_e z;
    flag_ovr_e h;
    flag_ovr_e pv;
    flag_ovr_e n;
    flag_ovr_e c;
  } flag_ovr_t;

  // one micro-operation, a new one arrives on every clock
  typedef struct packed {
    bus_src_e  src;
    reg_id_e   rd_reg;
    reg_id_e   wr_reg;
    logic      ld_reg;
    logic      ld_a;
    logic      ld_f;
    alu_op_e   alu_op;
    flag_ovr_t ovr;
    logic      exx;
    logic      ex_af;
    logic      ex_de_hl;
  } micro_op_t;

endpackage

//--- hw/z80_register_file.sv
`timescale 1ns/1ns

module z80_register_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  z80_dp_pkg::micro_op_t op,
  input  z80_dp_pkg::byte_t     load_value,
  output z80_dp_pkg::byte_t     reg_value
);

  import z80_dp_pkg::*;

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------

  // main set and shadow set, both indexed by the reg_id_e code
  byte_t main_q   [num_regs];
  byte_t shadow_q [num_regs];

  // codes 6 and 7 are not registers, so they must neither load nor read
  logic rd_valid;
  logic wr_valid;

  assign rd_valid = (op.rd_reg <= reg_l);
  assign wr_valid = (op.wr_reg <= reg_l);

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------

  // only the main set is visible, shadows come back only through exx
  always_comb begin
    if (rd_valid) begin
      reg_value = main_q[op.rd_reg];
    end else begin
      reg_value = '0;
    end
  end

  // ------------------------------------------------------------
  // exchanges and loads
  // ------------------------------------------------------------

  // priority is exx, then ex de,hl, then a plain load from the bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        main_q[i]   <= '0;
        shadow_q[i] <= '0;
      end
    end else if (op.exx) begin
      // the whole bank trades places with its shadow in one edge
      for (int i = 0; i < num_regs; i++) begin
        main_q[i]   <= shadow_q[i];
        shadow_q[i] <= main_q[i];
      end
    end else if (op.ex_de_hl) begin
      // DE and HL cross over, B and C are untouched
      main_q[reg_d] <= main_q[reg_h];
      main_q[reg_h] <= main_q[reg_d];
      main_q[reg_e] <= main_q[reg_l];
      main_q[reg_l] <= main_q[reg_e];
    end else if (op.ld_reg && wr_valid) begin
      // the load value is whatever the bus selector put on the bus
      main_q[op.wr_reg] <= load_value;
    end
  end

endmodule

//--- list.f
hw/z80_dp_pkg.sv
hw/z80_alu8.sv
hw/z80_register_file.sv
hw/z80_acc_flag_unit.sv
hw/z80_bus_select.sv
hw/z80_datapath.sv
test/z80_datapath_assertions.sv
test/z80_datapath_checker.sv
test/tb_z80_datapath.sv

//--- test/tb_z80_datapath.sv
`timescale 1ns/1ns

module tb_z80_datapath;

  import z80_dp_pkg::*;

  localparam int clk_period = 20;

  // one table row where exp_flags is what F holds after this row's edge
  typedef struct packed {
    micro_op_t op;
    byte_t     data_in;
    logic      rnd;
    byte_t     exp_out;
    logic      exp_oe;
    byte_t     exp_flags;
  } row_t;

  logic      clk;
  logic      arst_n;
  micro_op_t op;
  byte_t     data_in;
  byte_t     data_out;
  logic      data_oe;
  byte_t     flags;
  logic      check_en;
  byte_t     exp_out;
  logic      exp_oe;
  byte_t     exp_flags;
  int        error_count;
  int        check_count;
  row_t      rows[$];

  z80_datapath UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .op       (op),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .flags    (flags)
  );

  z80_datapath_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .check_en     (check_en),
    .data_out     (data_out),
    .data_oe      (data_oe),
    .flags        (flags),
    .exp_data_out (exp_out),
    .exp_data_oe  (exp_oe),
    .exp_flags    (exp_flags),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  bind z80_datapath z80_datapath_assertions u_assertions (
    .clk      (clk),
    .arst_n   (arst_n),
    .op       (op),
    .data_out (data_out),
    .data_oe  (data_oe),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ------------------------------------------------------------
  // table helpers
  // ------------------------------------------------------------

  // B gets 11, C gets 22 and so on up to L with 66
  function automatic byte_t reg_pattern(int i);
    return byte_t'((i + 1) * 'h11);
  endfunction

  // a micro-op that only puts one source on the bus
  function automatic micro_op_t plain_op(bus_src_e src, reg_id_e rd);
    micro_op_t m;
    m = '0;
    m.src = src;
    m.rd_reg = rd;
    return m;
  endfunction

  function automatic micro_op_t alu_step(bus_src_e src, alu_op_e fn, logic ld_a, logic ld_f);
    micro_op_t m;
    m = plain_op(src, reg_b);
    m.alu_op = fn;
    m.ld_a = ld_a;
    m.ld_f = ld_f;
    return m;
  endfunction

  function automatic void add_row(micro_op_t m, byte_t din, logic rnd,
                                  byte_t exp_o, logic exp_e, byte_t exp_f);
    row_t r;
    r = '{m, din, rnd, exp_o, exp_e, exp_f};
    rows.push_back(r);
  endfunction

  // ------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------
  task automatic build_table();
    micro_op_t m;
    // B..L load from the pins and are then read back through the bus
    for (int i = 0; i < num_regs; i++) begin
      m = plain_op(src_ext, reg_b);
      m.wr_reg = reg_id_e'(i[2:0]);
      m.ld_reg = 1'b1;
      add_row(m, reg_pattern(i), 1'b0, reg_pattern(i), 1'b0, 8'h00);
    end
    for (int i = 0; i < num_regs; i++) begin
      add_row(plain_op(src_reg, reg_id_e'(i[2:0])), 8'h00, 1'b0, reg_pattern(i), 1'b1, 8'h00);
    end
    // exx hides the bank behind the zeroed shadows and brings it back
    m = plain_op(src_ext, reg_b);
    m.exx = 1'b1;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    for (int i = 0; i < num_regs; i++) begin
      add_row(plain_op(src_reg, reg_id_e'(i[2:0])), 8'h00, 1'b0, 8'h00, 1'b1, 8'h00);
    end
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    for (int i = 0; i < num_regs; i++) begin
      add_row(plain_op(src_reg, reg_id_e'(i[2:0])), 8'h00, 1'b0, reg_pattern(i), 1'b1, 8'h00);
    end
    m = plain_op(src_ext, reg_b);
    m.ex_de_hl = 1'b1;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    add_row(plain_op(src_reg, reg_d), 8'h00, 1'b0, 8'h55, 1'b1, 8'h00);
    add_row(plain_op(src_reg, reg_e), 8'h00, 1'b0, 8'h66, 1'b1, 8'h00);
    add_row(plain_op(src_reg, reg_h), 8'h00, 1'b0, 8'h33, 1'b1, 8'h00);
    add_row(plain_op(src_reg, reg_l), 8'h00, 1'b0, 8'h44, 1'b1, 8'h00);

    // each ALU result is read back through src_a
    add_row(alu_step(src_ext, alu_pass, 1'b1, 1'b0), 8'h0f, 1'b0, 8'h0f, 1'b0, 8'h00);
    add_row(alu_step(src_ext, alu_inc, 1'b1, 1'b1), 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h10, 1'b1, 8'h00);
    add_row(alu_step(src_ext, alu_dec, 1'b1, 1'b1), 8'h00, 1'b0, 8'h00, 1'b0, 8'h04);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h0f, 1'b1, 8'h04);
    // 0f + 01 carries out of bit 3 only
    add_row(alu_step(src_ext, alu_add, 1'b1, 1'b1), 8'h01, 1'b0, 8'h01, 1'b0, 8'h14);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h10, 1'b1, 8'h14);
    // 10 + f0 wraps to zero with a carry out of bit 7
    add_row(alu_step(src_ext, alu_add, 1'b1, 1'b1), 8'hf0, 1'b0, 8'hf0, 1'b0, 8'h45);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h00, 1'b1, 8'h45);
    add_row(alu_step(src_ext, alu_pass, 1'b1, 1'b0), 8'h21, 1'b0, 8'h21, 1'b0, 8'h45);
    // 10 - 21 borrows from both nibbles and goes negative
    add_row(alu_step(src_ext, alu_sub, 1'b1, 1'b1), 8'h10, 1'b0, 8'h10, 1'b0, 8'h95);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'hef, 1'b1, 8'h95);
    add_row(alu_step(src_ext, alu_sub, 1'b1, 1'b1), 8'hef, 1'b0, 8'hef, 1'b0, 8'h44);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h00, 1'b1, 8'h44);
    // B still holds 11 and now feeds the ALU from the register file
    add_row(alu_step(src_reg, alu_add, 1'b1, 1'b1), 8'h00, 1'b0, 8'h11, 1'b1, 8'h04);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h11, 1'b1, 8'h04);

    // ------------------------------------------------------------
    // overrides on their own, then on top of an ALU flag write
    // ------------------------------------------------------------
    m = plain_op(src_ext, reg_b);
    m.ovr.s = ovr_set;
    m.ovr.c = ovr_set;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h85);
    m = plain_op(src_ext, reg_b);
    m.ovr.pv = ovr_clear;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h81);
    m = plain_op(src_ext, reg_b);
    m.ovr.n = ovr_set;
    m.ovr.z = ovr_set;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'hc3);
    add_row(plain_op(src_f, reg_b), 8'h00, 1'b0, 8'hc3, 1'b1, 8'hc3);
    // the add clears Z and C and the forces put them back without loading A
    m = alu_step(src_ext, alu_add, 1'b0, 1'b1);
    m.ovr.c = ovr_set;
    m.ovr.z = ovr_set;
    add_row(m, 8'h01, 1'b0, 8'h01, 1'b0, 8'h43);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h11, 1'b1, 8'h43);

    // A and F trade places with the shadow pair that is still zero from reset
    m = plain_op(src_ext, reg_b);
    m.ex_af = 1'b1;
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h00, 1'b1, 8'h00);
    add_row(plain_op(src_f, reg_b), 8'h00, 1'b0, 8'h00, 1'b1, 8'h00);
    add_row(alu_step(src_ext, alu_pass, 1'b1, 1'b0), 8'h5a, 1'b0, 8'h5a, 1'b0, 8'h00);
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h43);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h11, 1'b1, 8'h43);
    add_row(plain_op(src_f, reg_b), 8'h00, 1'b0, 8'h43, 1'b1, 8'h43);
    add_row(m, 8'h00, 1'b0, 8'h00, 1'b0, 8'h00);
    add_row(plain_op(src_a, reg_b), 8'h00, 1'b0, 8'h5a, 1'b1, 8'h00);

    // external data passes straight through and its expected value is set when applied
    for (int i = 0; i < 8; i++) begin
      add_row(plain_op(src_ext, reg_b), 8'h00, 1'b1, 8'h00, 1'b0, 8'h00);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    byte_t din;
    int    assert_fails;
    void'($urandom(42466));
    arst_n    = 1'b0;
    op        = '0;
    data_in   = '0;
    check_en  = 1'b0;
    exp_out   = '0;
    exp_oe    = 1'b0;
    exp_flags = '0;
    build_table();
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    foreach (rows[k]) begin
      @(posedge clk);
      din = rows[k].rnd ? byte_t'($urandom) : rows[k].data_in;
      op        <= rows[k].op;
      data_in   <= din;
      exp_out   <= rows[k].rnd ? din : rows[k].exp_out;
      exp_oe    <= rows[k].exp_oe;
      exp_flags <= rows[k].exp_flags;
      check_en  <= 1'b1;
    end
    // one idle cycle lets the checker see the flags of the last row
    @(posedge clk);
    op       <= '0;
    data_in  <= '0;
    check_en <= 1'b0;
    repeat (2) @(posedge clk);
    assert_fails = UUT.u_assertions.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if ((error_count == 0) && (assert_fails == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    int limit_ns;
    #1;
    limit_ns = (rows.size() + 10) * clk_period;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- test/z80_datapath_assertions.sv
`timescale 1ns/1ns

module z80_datapath_assertions (
  input logic                  clk,
  input logic                  arst_n,
  input z80_dp_pkg::micro_op_t op,
  input z80_dp_pkg::byte_t     data_out,
  input logic                  data_oe,
  input z80_dp_pkg::byte_t     flags
);

  import z80_dp_pkg::*;

  // number of property failures seen during the run
  int fail_count = 0;

  // the pins are only driven when an internal block owns the bus
  a_oe_low_on_ext : assert property (@(posedge clk) disable iff (!arst_n)
    (op.src == src_ext) |-> !data_oe)
    else begin
      fail_count++;
      $error("data_oe is high while the bus takes external data");
    end

  // F may only move on ld_f, an override or the A/F exchange
  a_flags_hold : assert property (@(posedge clk) disable iff (!arst_n)
    (!op.ld_f && (op.ovr == '0) && !op.ex_af) |=> $stable(flags))
    else begin
      fail_count++;
      $error("flags changed in a cycle that does not write F");
    end

  a_out_known : assert property (@(posedge clk) disable iff (!arst_n)
    data_oe |-> !$isunknown(data_out))
    else begin
      fail_count++;
      $error("data_out has unknown bits while data_oe is high");
    end

endmodule

//--- test/z80_datapath_checker.sv
`timescale 1ns/1ns

module z80_datapath_checker (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              check_en,
  input  z80_dp_pkg::byte_t data_out,
  input  logic              data_oe,
  input  z80_dp_pkg::byte_t flags,
  input  z80_dp_pkg::byte_t exp_data_out,
  input  logic              exp_data_oe,
  input  z80_dp_pkg::byte_t exp_flags,
  output int                error_count,
  output int                check_count
);

  import z80_dp_pkg::*;

  int    errors = 0;
  int    checks = 0;
  // the flag expectation of a row only becomes visible one cycle later
  byte_t pending_flags = '0;
  logic  pending_valid = 1'b0;

  // ------------------------------------------------------------
  // compare in the middle of the cycle where everything is settled
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (!arst_n) begin
      pending_valid = 1'b0;
    end else begin
      // F written at the edge that ended the previous row
      if (pending_valid) begin
        checks++;
        if (flags !== pending_flags) begin
          errors++;
          $display("MISMATCH at %0t: flags is %h, expected %h", $time, flags, pending_flags);
        end
      end
      // the bus outputs follow the current row combinationally
      if (check_en) begin
        checks += 2;
        if (data_out !== exp_data_out) begin
          errors++;
          $display("MISMATCH at %0t: data_out is %h, expected %h",
                   $time, data_out, exp_data_out);
        end
        if (data_oe !== exp_data_oe) begin
          errors++;
          $display("MISMATCH at %0t: data_oe is %b, expected %b", $time, data_oe, exp_data_oe);
        end
      end
      pending_valid = check_en;
      pending_flags = exp_flags;
    end
  end

  assign error_count = errors;
  assign check_count = checks;

endmodule
